// ==== source/csr_pkg.sv ====
package csr_pkg;

    // ================================================
    // Widths
    // ================================================
    typedef logic [31:0] csr_word_t;
    typedef logic [11:0] csr_addr_t;

    // CSR instruction operation
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_write = 2'd1,
        op_set   = 2'd2,
        op_clear = 2'd3
    } csr_op_e;

    // One selector per implemented register
    typedef enum logic [4:0] {
        sel_none,
        sel_mstatus,
        sel_misa,
        sel_mie,
        sel_mtvec,
        sel_mscratch,
        sel_mepc,
        sel_mcause,
        sel_mtval,
        sel_mip,
        sel_mhartid,
        sel_mcycle,
        sel_mcycleh,
        sel_minstret,
        sel_minstreth,
        // Read-only user aliases of the counters
        sel_cycle,
        sel_cycleh,
        sel_instret,
        sel_instreth
    } csr_sel_e;

    // ================================================
    // Addresses
    // ================================================
    localparam csr_addr_t addr_mstatus   = 12'h300;
    localparam csr_addr_t addr_misa      = 12'h301;
    localparam csr_addr_t addr_mie       = 12'h304;
    localparam csr_addr_t addr_mtvec     = 12'h305;
    localparam csr_addr_t addr_mscratch  = 12'h340;
    localparam csr_addr_t addr_mepc      = 12'h341;
    localparam csr_addr_t addr_mcause    = 12'h342;
    localparam csr_addr_t addr_mtval     = 12'h343;
    localparam csr_addr_t addr_mip       = 12'h344;
    localparam csr_addr_t addr_mhartid   = 12'hF14;
    localparam csr_addr_t addr_mcycle    = 12'hB00;
    localparam csr_addr_t addr_minstret  = 12'hB02;
    localparam csr_addr_t addr_mcycleh   = 12'hB80;
    localparam csr_addr_t addr_minstreth = 12'hB82;
    localparam csr_addr_t addr_cycle     = 12'hC00;
    localparam csr_addr_t addr_instret   = 12'hC02;
    localparam csr_addr_t addr_cycleh    = 12'hC80;
    localparam csr_addr_t addr_instreth  = 12'hC82;

    // ================================================
    // Exception causes and trap vectors
    // ================================================
    localparam csr_word_t cause_illegal_inst = 32'd2;
    localparam csr_word_t cause_misaligned   = 32'd4;
    localparam csr_word_t cause_illegal_csr  = 32'd11;
    localparam csr_word_t cause_breakpoint   = 32'd3;

    localparam csr_word_t vec_illegal_inst = 32'h0000_0100;
    localparam csr_word_t vec_misaligned   = 32'h0000_0200;
    localparam csr_word_t vec_illegal_csr  = 32'h0000_0300;
    localparam csr_word_t vec_breakpoint   = 32'h0000_0400;

    // Next value of a register under write, set or clear
    function automatic csr_word_t apply_op(csr_op_e op, csr_word_t cur, csr_word_t operand);
        case (op)
            op_write: return operand;
            op_set:   return cur | operand;
            op_clear: return cur & ~operand;
            default:  return cur;
        endcase
    endfunction

endpackage

// ==== source/csr_access_if.sv ====
interface csr_access_if;

    csr_pkg::csr_op_e   wr_op;
    logic               rd_en;
    csr_pkg::csr_sel_e  sel;
    csr_pkg::csr_word_t operand;

    // Decoder side produces the access
    modport decoder (
        output wr_op,
        output rd_en,
        output sel,
        output operand
    );

    // Register banks only care about writes
    modport update (input wr_op, input sel, input operand);

    modport read (input rd_en, input sel);

endinterface

// ==== source/csr_access_decode.sv ====
module csr_access_decode (
    input  logic               csr_wren,
    input  logic               csr_rden,
    input  csr_pkg::csr_op_e   csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               csr_imm_bit,
    input  csr_pkg::csr_word_t csr_data_imm,
    input  csr_pkg::csr_word_t write_data,
    csr_access_if.decoder      acc
);

    csr_pkg::csr_sel_e sel;
    logic              read_only;

    // ================================================
    // Address to selector
    // ================================================
    always_comb begin
        case (csr_addr)
            csr_pkg::addr_mstatus:   sel = csr_pkg::sel_mstatus;
            csr_pkg::addr_misa:      sel = csr_pkg::sel_misa;
            csr_pkg::addr_mie:       sel = csr_pkg::sel_mie;
            csr_pkg::addr_mtvec:     sel = csr_pkg::sel_mtvec;
            csr_pkg::addr_mscratch:  sel = csr_pkg::sel_mscratch;
            csr_pkg::addr_mepc:      sel = csr_pkg::sel_mepc;
            csr_pkg::addr_mcause:    sel = csr_pkg::sel_mcause;
            csr_pkg::addr_mtval:     sel = csr_pkg::sel_mtval;
            csr_pkg::addr_mip:       sel = csr_pkg::sel_mip;
            csr_pkg::addr_mhartid:   sel = csr_pkg::sel_mhartid;
            csr_pkg::addr_mcycle:    sel = csr_pkg::sel_mcycle;
            csr_pkg::addr_mcycleh:   sel = csr_pkg::sel_mcycleh;
            csr_pkg::addr_minstret:  sel = csr_pkg::sel_minstret;
            csr_pkg::addr_minstreth: sel = csr_pkg::sel_minstreth;
            csr_pkg::addr_cycle:     sel = csr_pkg::sel_cycle;
            csr_pkg::addr_cycleh:    sel = csr_pkg::sel_cycleh;
            csr_pkg::addr_instret:   sel = csr_pkg::sel_instret;
            csr_pkg::addr_instreth:  sel = csr_pkg::sel_instreth;
            default:                 sel = csr_pkg::sel_none;
        endcase
    end

    // Hart id and user counter aliases ignore writes
    assign read_only = (sel == csr_pkg::sel_mhartid) ||
                       (sel == csr_pkg::sel_cycle)   || (sel == csr_pkg::sel_cycleh) ||
                       (sel == csr_pkg::sel_instret) || (sel == csr_pkg::sel_instreth);

    assign acc.sel     = sel;
    assign acc.rd_en   = csr_rden;
    assign acc.operand = csr_imm_bit ? csr_data_imm : write_data;
    assign acc.wr_op   = (csr_wren && sel != csr_pkg::sel_none && !read_only) ?
                         csr_op : csr_pkg::op_none;

    // Every decoded write names a register
    always_comb begin
        if (acc.wr_op != csr_pkg::op_none) begin
            assert (acc.sel != csr_pkg::sel_none)
                else $error("write issued without a decoded register");
        end
    end

endmodule

// ==== source/csr_trap_regs.sv ====
module csr_trap_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_word_t pc,
    input  logic               illegal_instruction,
    input  logic               misaligned_access,
    input  logic               illegal_csr_access,
    input  logic               breakpoint,
    csr_access_if.update       acc,
    output csr_pkg::csr_word_t mstatus,
    output csr_pkg::csr_word_t misa,
    output csr_pkg::csr_word_t mie,
    output csr_pkg::csr_word_t mtvec,
    output csr_pkg::csr_word_t mscratch,
    output csr_pkg::csr_word_t mepc,
    output csr_pkg::csr_word_t mcause,
    output csr_pkg::csr_word_t mtval,
    output csr_pkg::csr_word_t mip
);

    csr_pkg::csr_word_t mstatus_d, misa_d, mie_d, mtvec_d, mscratch_d;
    csr_pkg::csr_word_t mepc_d, mcause_d, mtval_d, mip_d;
    csr_pkg::csr_word_t exc_cause, exc_vec;
    logic               exc_any;

    assign exc_any = breakpoint | illegal_csr_access | misaligned_access | illegal_instruction;

    // Highest priority strobe picks cause and vector
    always_comb begin
        if (breakpoint) begin
            exc_cause = csr_pkg::cause_breakpoint;
            exc_vec   = csr_pkg::vec_breakpoint;
        end else if (illegal_csr_access) begin
            exc_cause = csr_pkg::cause_illegal_csr;
            exc_vec   = csr_pkg::vec_illegal_csr;
        end else if (misaligned_access) begin
            exc_cause = csr_pkg::cause_misaligned;
            exc_vec   = csr_pkg::vec_misaligned;
        end else begin
            exc_cause = csr_pkg::cause_illegal_inst;
            exc_vec   = csr_pkg::vec_illegal_inst;
        end
    end

    // ================================================
    // Next state
    // ================================================
    always_comb begin
        mstatus_d  = mstatus;
        misa_d     = misa;
        mie_d      = mie;
        mtvec_d    = mtvec;
        mscratch_d = mscratch;
        mepc_d     = mepc;
        mcause_d   = mcause;
        mtval_d    = mtval;
        mip_d      = mip;

        case (acc.sel)
            csr_pkg::sel_mstatus:  mstatus_d  = csr_pkg::apply_op(acc.wr_op, mstatus, acc.operand);
            csr_pkg::sel_misa:     misa_d     = csr_pkg::apply_op(acc.wr_op, misa, acc.operand);
            csr_pkg::sel_mie:      mie_d      = csr_pkg::apply_op(acc.wr_op, mie, acc.operand);
            csr_pkg::sel_mtvec:    mtvec_d    = csr_pkg::apply_op(acc.wr_op, mtvec, acc.operand);
            csr_pkg::sel_mscratch: mscratch_d = csr_pkg::apply_op(acc.wr_op, mscratch, acc.operand);
            csr_pkg::sel_mepc:     mepc_d     = csr_pkg::apply_op(acc.wr_op, mepc, acc.operand);
            csr_pkg::sel_mcause:   mcause_d   = csr_pkg::apply_op(acc.wr_op, mcause, acc.operand);
            csr_pkg::sel_mtval:    mtval_d    = csr_pkg::apply_op(acc.wr_op, mtval, acc.operand);
            csr_pkg::sel_mip:      mip_d      = csr_pkg::apply_op(acc.wr_op, mip, acc.operand);
            default: ;
        endcase

        // Hardware trap wins over the software update
        if (exc_any) begin
            mcause_d = exc_cause;
            mtvec_d  = exc_vec;
            mepc_d   = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus  <= '0;
            misa     <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mip      <= '0;
        end else begin
            mstatus  <= mstatus_d;
            misa     <= misa_d;
            mie      <= mie_d;
            mtvec    <= mtvec_d;
            mscratch <= mscratch_d;
            mepc     <= mepc_d;
            mcause   <= mcause_d;
            mtval    <= mtval_d;
            mip      <= mip_d;
        end
    end

    // Faulting pc lands in mepc one cycle later
    a_mepc_capture: assert property (@(posedge clk) disable iff (!rst_n)
        exc_any |=> mepc == $past(pc))
        else $error("mepc does not hold the pc of the exception cycle");

endmodule

// ==== source/csr_counters.sv ====
module csr_counters (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_valid,
    csr_access_if.update       acc,
    output csr_pkg::csr_word_t cycle_lo,
    output csr_pkg::csr_word_t cycle_hi,
    output csr_pkg::csr_word_t instret_lo,
    output csr_pkg::csr_word_t instret_hi
);

    csr_pkg::csr_word_t cycle_lo_d, cycle_hi_d;
    csr_pkg::csr_word_t instret_lo_d, instret_hi_d;
    logic               cycle_carry;
    logic               instret_carry;

    // ================================================
    // Increment with carry, then software override
    // ================================================
    always_comb begin
        {cycle_carry, cycle_lo_d} = {1'b0, cycle_lo} + 33'd1;
        cycle_hi_d = cycle_hi + {31'd0, cycle_carry};

        {instret_carry, instret_lo_d} = {1'b0, instret_lo} + {32'd0, inst_valid};
        instret_hi_d = instret_hi + {31'd0, instret_carry};

        // A written half takes the software value while the other half keeps counting
        if (acc.wr_op != csr_pkg::op_none) begin
            case (acc.sel)
                csr_pkg::sel_mcycle:
                    cycle_lo_d = csr_pkg::apply_op(acc.wr_op, cycle_lo, acc.operand);
                csr_pkg::sel_mcycleh:
                    cycle_hi_d = csr_pkg::apply_op(acc.wr_op, cycle_hi, acc.operand);
                csr_pkg::sel_minstret:
                    instret_lo_d = csr_pkg::apply_op(acc.wr_op, instret_lo, acc.operand);
                csr_pkg::sel_minstreth:
                    instret_hi_d = csr_pkg::apply_op(acc.wr_op, instret_hi, acc.operand);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_lo   <= '0;
            cycle_hi   <= '0;
            instret_lo <= '0;
            instret_hi <= '0;
        end else begin
            cycle_lo   <= cycle_lo_d;
            cycle_hi   <= cycle_hi_d;
            instret_lo <= instret_lo_d;
            instret_hi <= instret_hi_d;
        end
    end

    // Low half wrap must reach the high half
    a_cycle_carry: assert property (@(posedge clk) disable iff (!rst_n)
        (acc.wr_op == csr_pkg::op_none && cycle_lo == '1)
        |=> cycle_hi == $past(cycle_hi) + 32'd1)
        else $error("cycle counter lost the carry into the high half");

endmodule

// ==== source/csr_read_mux.sv ====
module csr_read_mux #(
    parameter csr_pkg::csr_word_t HART_ID = 32'h0
) (
    csr_access_if.read         acc,
    input  csr_pkg::csr_word_t mstatus,
    input  csr_pkg::csr_word_t misa,
    input  csr_pkg::csr_word_t mie,
    input  csr_pkg::csr_word_t mtvec,
    input  csr_pkg::csr_word_t mscratch,
    input  csr_pkg::csr_word_t mepc,
    input  csr_pkg::csr_word_t mcause,
    input  csr_pkg::csr_word_t mtval,
    input  csr_pkg::csr_word_t mip,
    input  csr_pkg::csr_word_t cycle_lo,
    input  csr_pkg::csr_word_t cycle_hi,
    input  csr_pkg::csr_word_t instret_lo,
    input  csr_pkg::csr_word_t instret_hi,
    output csr_pkg::csr_word_t read_data
);

    // ================================================
    // Read select
    // ================================================
    always_comb begin
        read_data = '0;
        if (acc.rd_en) begin
            case (acc.sel)
                csr_pkg::sel_mstatus:  read_data = mstatus;
                csr_pkg::sel_misa:     read_data = misa;
                csr_pkg::sel_mie:      read_data = mie;
                csr_pkg::sel_mtvec:    read_data = mtvec;
                csr_pkg::sel_mscratch: read_data = mscratch;
                csr_pkg::sel_mepc:     read_data = mepc;
                csr_pkg::sel_mcause:   read_data = mcause;
                csr_pkg::sel_mtval:    read_data = mtval;
                csr_pkg::sel_mip:      read_data = mip;
                csr_pkg::sel_mhartid:  read_data = HART_ID;
                // Machine counters and their user aliases share storage
                csr_pkg::sel_mcycle,
                csr_pkg::sel_cycle:     read_data = cycle_lo;
                csr_pkg::sel_mcycleh,
                csr_pkg::sel_cycleh:    read_data = cycle_hi;
                csr_pkg::sel_minstret,
                csr_pkg::sel_instret:   read_data = instret_lo;
                csr_pkg::sel_minstreth,
                csr_pkg::sel_instreth:  read_data = instret_hi;
                default:               read_data = '0;
            endcase
        end
    end

endmodule

// ==== source/csr_file_top.sv ====
module csr_file_top #(
    parameter csr_pkg::csr_word_t HART_ID = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pc,
    input  logic [31:0] write_data,
    input  logic [31:0] csr_data_imm,
    input  logic        csr_wren,
    input  logic        csr_rden,
    input  logic        csr_imm_bit,
    input  logic        inst_valid,
    input  logic [1:0]  csr_op,
    input  logic [11:0] csr_addr,
    input  logic        illegal_instruction,
    input  logic        misaligned_access,
    input  logic        illegal_csr_access,
    input  logic        breakpoint,
    output logic [31:0] read_data
);

    csr_access_if acc ();

    // Register values toward the read side
    csr_pkg::csr_word_t mstatus, misa, mie, mtvec, mscratch;
    csr_pkg::csr_word_t mepc, mcause, mtval, mip;
    csr_pkg::csr_word_t cycle_lo, cycle_hi, instret_lo, instret_hi;

    // ================================================
    // Decode
    // ================================================
    csr_access_decode u_decode (
        .csr_wren     (csr_wren),
        .csr_rden     (csr_rden),
        .csr_op       (csr_pkg::csr_op_e'(csr_op)),
        .csr_addr     (csr_addr),
        .csr_imm_bit  (csr_imm_bit),
        .csr_data_imm (csr_data_imm),
        .write_data   (write_data),
        .acc          (acc.decoder)
    );

    // ================================================
    // Storage
    // ================================================
    csr_trap_regs u_trap_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pc                  (pc),
        .illegal_instruction (illegal_instruction),
        .misaligned_access   (misaligned_access),
        .illegal_csr_access  (illegal_csr_access),
        .breakpoint          (breakpoint),
        .acc                 (acc.update),
        .mstatus             (mstatus),
        .misa                (misa),
        .mie                 (mie),
        .mtvec               (mtvec),
        .mscratch            (mscratch),
        .mepc                (mepc),
        .mcause              (mcause),
        .mtval               (mtval),
        .mip                 (mip)
    );

    csr_counters u_counters (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .acc        (acc.update),
        .cycle_lo   (cycle_lo),
        .cycle_hi   (cycle_hi),
        .instret_lo (instret_lo),
        .instret_hi (instret_hi)
    );

    // ================================================
    // Read back
    // ================================================
    csr_read_mux #(
        .HART_ID (HART_ID)
    ) u_read_mux (
        .acc        (acc.read),
        .mstatus    (mstatus),
        .misa       (misa),
        .mie        (mie),
        .mtvec      (mtvec),
        .mscratch   (mscratch),
        .mepc       (mepc),
        .mcause     (mcause),
        .mtval      (mtval),
        .mip        (mip),
        .cycle_lo   (cycle_lo),
        .cycle_hi   (cycle_hi),
        .instret_lo (instret_lo),
        .instret_hi (instret_hi),
        .read_data  (read_data)
    );

endmodule

// ==== testbench/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== testbench/csr_file_tb.sv ====
module csr_file_tb;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc, write_data, csr_data_imm, read_data;
    logic        csr_wren, csr_rden, csr_imm_bit, inst_valid;
    logic [1:0]  csr_op;
    logic [11:0] csr_addr;
    logic        illegal_instruction, misaligned_access, illegal_csr_access, breakpoint;

    // Reference model state
    logic [31:0] trap_m [9];
    logic [63:0] cyc_m, ins_m;
    logic [31:0] exp_read;
    logic [31:0] r;

    // Model index order is mstatus misa mie mtvec mscratch mepc mcause mtval mip
    localparam logic [11:0] trap_addr [9] = '{
        csr_pkg::addr_mstatus, csr_pkg::addr_misa, csr_pkg::addr_mie,
        csr_pkg::addr_mtvec, csr_pkg::addr_mscratch, csr_pkg::addr_mepc,
        csr_pkg::addr_mcause, csr_pkg::addr_mtval, csr_pkg::addr_mip
    };
    localparam logic [11:0] ro_addr [5] = '{
        csr_pkg::addr_mhartid, csr_pkg::addr_cycle, csr_pkg::addr_cycleh,
        csr_pkg::addr_instret, csr_pkg::addr_instreth
    };
    localparam logic [11:0] cnt_addr [8] = '{
        csr_pkg::addr_mcycle, csr_pkg::addr_cycle, csr_pkg::addr_mcycleh,
        csr_pkg::addr_cycleh, csr_pkg::addr_minstret, csr_pkg::addr_instret,
        csr_pkg::addr_minstreth, csr_pkg::addr_instreth
    };

    tb_clk_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    csr_file_top #(.HART_ID(32'h0000_0005)) u_dut (.*);

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] op_result(input logic [1:0] op, input logic [31:0] cur,
                                              input logic [31:0] opd);
        case (op)
            2'd1:    return opd;
            2'd2:    return cur | opd;
            2'd3:    return cur & ~opd;
            default: return cur;
        endcase
    endfunction

    // ==================================================
    // Reference model
    // ==================================================
    always_comb begin
        exp_read = 32'h0;
        for (int i = 0; i < 9; i++) begin
            if (csr_addr == trap_addr[i]) begin
                exp_read = trap_m[i];
            end
        end
        case (csr_addr)
            csr_pkg::addr_mhartid:                           exp_read = 32'h0000_0005;
            csr_pkg::addr_mcycle, csr_pkg::addr_cycle:       exp_read = cyc_m[31:0];
            csr_pkg::addr_mcycleh, csr_pkg::addr_cycleh:     exp_read = cyc_m[63:32];
            csr_pkg::addr_minstret, csr_pkg::addr_instret:   exp_read = ins_m[31:0];
            csr_pkg::addr_minstreth, csr_pkg::addr_instreth: exp_read = ins_m[63:32];
            default: ;
        endcase
        if (!csr_rden) begin
            exp_read = 32'h0;
        end
    end

    always @(posedge clk) begin : model_step
        logic [31:0] opd;
        logic [63:0] cyc_n, ins_n;
        logic        wr;
        opd   = csr_imm_bit ? csr_data_imm : write_data;
        wr    = csr_wren && csr_op != 2'd0;
        cyc_n = cyc_m + 64'd1;
        ins_n = ins_m + {63'd0, inst_valid};
        if (wr && csr_addr == csr_pkg::addr_mcycle) begin
            cyc_n[31:0] = op_result(csr_op, cyc_m[31:0], opd);
        end
        if (wr && csr_addr == csr_pkg::addr_mcycleh) begin
            cyc_n[63:32] = op_result(csr_op, cyc_m[63:32], opd);
        end
        if (wr && csr_addr == csr_pkg::addr_minstret) begin
            ins_n[31:0] = op_result(csr_op, ins_m[31:0], opd);
        end
        if (wr && csr_addr == csr_pkg::addr_minstreth) begin
            ins_n[63:32] = op_result(csr_op, ins_m[63:32], opd);
        end
        if (!rst_n) begin
            for (int i = 0; i < 9; i++) trap_m[i] <= 32'h0;
            cyc_m <= 64'h0;
            ins_m <= 64'h0;
        end else begin
            for (int i = 0; i < 9; i++) begin
                if (wr && csr_addr == trap_addr[i]) begin
                    trap_m[i] <= op_result(csr_op, trap_m[i], opd);
                end
            end
            // Trap capture overrides the software write
            if (breakpoint) begin
                trap_m[6] <= 32'd3;
                trap_m[3] <= 32'h400;
            end else if (illegal_csr_access) begin
                trap_m[6] <= 32'd11;
                trap_m[3] <= 32'h300;
            end else if (misaligned_access) begin
                trap_m[6] <= 32'd4;
                trap_m[3] <= 32'h200;
            end else if (illegal_instruction) begin
                trap_m[6] <= 32'd2;
                trap_m[3] <= 32'h100;
            end
            if (breakpoint | illegal_csr_access | misaligned_access | illegal_instruction) begin
                trap_m[5] <= pc;
            end
            cyc_m <= cyc_n;
            ins_m <= ins_n;
        end
    end

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n) read_data == exp_read)
        else begin
            $display("ERR read_data addr %h expected %h actual %h",
                     $sampled(csr_addr), $sampled(exp_read), $sampled(read_data));
            stop_with_failure("read data does not match the model");
        end

    // Holds in reset too
    a_idle_zero: assert property (@(posedge clk) !csr_rden |-> read_data == 32'h0)
        else begin
            $display("ERR read_data expected %h actual %h", 32'h0, $sampled(read_data));
            stop_with_failure("read data not zero without a read");
        end

    // ==================================================
    // Stimulus
    // ==================================================
    // One cycle of inputs with the operand on a random source
    task automatic drive(input logic wren, input logic rden, input logic [1:0] op,
                         input logic [11:0] addr, input logic [31:0] value,
                         input logic [3:0] exc);
        r = $urandom;
        csr_wren     = wren;
        csr_rden     = rden;
        csr_op       = op;
        csr_addr     = addr;
        csr_imm_bit  = r[0];
        inst_valid   = r[1];
        csr_data_imm = r[0] ? value : $urandom;
        write_data   = r[0] ? $urandom : value;
        pc           = $urandom;
        {breakpoint, illegal_csr_access, misaligned_access, illegal_instruction} = exc;
        @(negedge clk);
    endtask

    task automatic read(input logic [11:0] addr);
        drive(1'b0, 1'b1, 2'd0, addr, 32'h0, 4'h0);
    endtask

    task automatic read_trap_outcome();
        read(csr_pkg::addr_mcause);
        read(csr_pkg::addr_mtvec);
        read(csr_pkg::addr_mepc);
    endtask

    initial begin
        logic [11:0] a;
        int          n;
        r = $urandom(32'h8831);
        {csr_wren, csr_rden, csr_imm_bit, inst_valid, csr_op, csr_addr} = '0;
        {pc, write_data, csr_data_imm} = '0;
        {breakpoint, illegal_csr_access, misaligned_access, illegal_instruction} = 4'h0;

        n = 0;
        while (!rst_n) begin
            @(negedge clk);
            n++;
            if (n > 10) stop_with_failure("reset was never released");
        end

        for (int i = 0; i < 9; i++) read(trap_addr[i]);
        read(csr_pkg::addr_mhartid);

        // Software updates read back in the next cycle
        repeat (300) begin
            r = $urandom;
            a = trap_addr[r[7:4] % 4'd9];
            drive(1'b1, r[8], r[3:2], a, $urandom, 4'h0);
            read(a);
        end

        repeat (20) begin
            r = $urandom;
            drive(1'b0, 1'b0, 2'd0, trap_addr[r[3:0] % 4'd9], 32'h0, 4'h0);
        end
        drive(1'b1, 1'b1, 2'd1, 12'h7C0, 32'hFFFF_FFFF, 4'h0);
        read(12'h7C0);
        for (int i = 0; i < 5; i++) begin
            drive(1'b1, 1'b0, 2'd1, ro_addr[i], 32'hA5A5_5A5A, 4'h0);
            read(ro_addr[i]);
        end

        // Single exceptions against a write to mcause and then mixed strobes
        for (int i = 0; i < 4; i++) begin
            drive(1'b1, 1'b0, 2'd1, csr_pkg::addr_mcause, 32'h7F, 4'(1 << i));
            read_trap_outcome();
        end
        repeat (40) begin
            r = $urandom;
            drive(1'b1, 1'b1, 2'd1, trap_addr[r[7:4] % 4'd9], $urandom, r[3:0]);
            read_trap_outcome();
        end

        read(csr_pkg::addr_mcycle);
        repeat (7) drive(1'b0, 1'b0, 2'd0, 12'h0, 32'h0, 4'h0);
        for (int i = 0; i < 8; i++) read(cnt_addr[i]);

        // Low half wrap into cycleh
        drive(1'b1, 1'b0, 2'd1, csr_pkg::addr_mcycleh, 32'h0, 4'h0);
        drive(1'b1, 1'b0, 2'd1, csr_pkg::addr_mcycle, 32'hFFFF_FFFF, 4'h0);
        n = 0;
        do begin
            read(csr_pkg::addr_mcycleh);
            n++;
            if (n > 5) stop_with_failure("carry into cycleh never appeared");
        end while (read_data == 32'h0);
        read(csr_pkg::addr_mcycleh);
        read(csr_pkg::addr_cycleh);

        repeat (10) begin
            r = $urandom;
            drive(1'b1, 1'b1, r[1:0], r[2] ? csr_pkg::addr_minstreth : csr_pkg::addr_minstret,
                  $urandom, 4'h0);
            for (int i = 4; i < 8; i++) read(cnt_addr[i]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
source/csr_pkg.sv
source/csr_access_if.sv
source/csr_access_decode.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_read_mux.sv
source/csr_file_top.sv
testbench/tb_clk_gen.sv
testbench/csr_file_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module csr_file_tb -f flist.f -o sim_csr_file
./obj_dir/sim_csr_file | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    exit 1
fi
